// ==== panel_defs.svh ====
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// ********************
// scan timing
// ********************

// clock cycles spent on each register slot of the external board
`define SCAN_DIV 16

// ********************
// board geometry
// ********************

// CPU registers shown on the GPIO board, one per scan slot
`define NUM_REGS 8

// seven-segment digits on the GPIO board, data nibbles first
`define NUM_DIGITS 8

// nibbles in one 16-bit bus value
`define NIBBLES_PER_WORD 4

`endif

// ==== probe_pkg.sv ====
`default_nettype none
`include "panel_defs.svh"

package probe_pkg;

    typedef logic [15:0] word_t;                  // native width of the teaching CPU
    typedef word_t [`NUM_REGS-1:0] reg_file_t;    // r0 sits in the lowest word

    // ********************
    // instruction word views
    // ********************

    typedef struct packed {
        logic [7:0]  opcode;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [11:0] unused;                      // reserved by the ISA
    } r_fmt_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [3:0]  rd;
        logic [19:0] imm;
    } i_fmt_t;

    // the opcode sits in the same place in both views, so either one may be used to pick the view
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

    localparam int IMM_FMT_BIT = 7;               // opcode bit that marks the immediate view

    // ********************
    // core snapshot
    // ********************

    typedef struct packed {
        word_t       data;                        // low half of the data bus
        word_t       address;                     // low half of the address bus
        word_t       pc;                          // low half of the program counter
        instr_word_u instr;
        reg_file_t   regs;
    } probe_t;

endpackage

`default_nettype wire

// ==== panel_pkg.sv ====
`default_nettype none
`include "panel_defs.svh"

package panel_pkg;

    typedef logic [6:0] seg_t;                    // segment a in bit 0, g in bit 6

    // active-high patterns for the eight digits of the GPIO board
    typedef struct packed {
        seg_t [`NIBBLES_PER_WORD-1:0] addr;       // digits 4 to 7
        seg_t [`NIBBLES_PER_WORD-1:0] data;       // digits 0 to 3
    } seg_frame_t;

    // ********************
    // GPIO header word
    // ********************

    typedef struct packed {
        logic [15:0]             reg_value;       // register of the current slot
        logic [`NUM_DIGITS-1:0]  digit_sel;       // one-hot, bit n lights digit n
        seg_t                    seg_n;           // common-anode board, so 0 lights a segment
        logic                    slot_start;      // high for the first cycle of a slot
    } gpio_word_t;

    // board idles with every digit deselected and every segment dark
    localparam gpio_word_t GPIO_IDLE = '{
        reg_value:  16'h0000,
        digit_sel:  '0,
        seg_n:      7'h7f,
        slot_start: 1'b0
    };

    // standard hex font, active high
    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t seg;
        case (nibble)
            4'h0:    seg = 7'h3f;
            4'h1:    seg = 7'h06;
            4'h2:    seg = 7'h5b;
            4'h3:    seg = 7'h4f;
            4'h4:    seg = 7'h66;
            4'h5:    seg = 7'h6d;
            4'h6:    seg = 7'h7d;
            4'h7:    seg = 7'h07;
            4'h8:    seg = 7'h7f;
            4'h9:    seg = 7'h6f;
            4'ha:    seg = 7'h77;
            4'hb:    seg = 7'h7c;             // lower case b keeps it apart from 8
            4'hc:    seg = 7'h39;
            4'hd:    seg = 7'h5e;             // lower case d keeps it apart from 0
            4'he:    seg = 7'h79;
            default: seg = 7'h71;             // F
        endcase
        return seg;
    endfunction

endpackage

`default_nettype wire

// ==== probe_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "panel_defs.svh"

module probe_decoder
    import probe_pkg::*;
    import panel_pkg::*;
(
    input  logic                         clock,
    input  logic                         rst,
    input  probe_t                       probe,
    output seg_frame_t                   seg_frame,
    output seg_t [`NIBBLES_PER_WORD-1:0] hex,
    output logic [9:0]                   leds
);

    logic [9:0] leds_d;

    // ********************
    // instruction LEDs
    // ********************

    always_comb begin
        if (probe.instr.i_fmt.opcode[IMM_FMT_BIT]) begin
            // immediate format lights the top LED and shows the low immediate bits
            leds_d = {1'b1, probe.instr.i_fmt.imm[8:0]};
        end else begin
            leds_d = {1'b0,
                      probe.instr.r_fmt.rd[2:0],          // leds 8 to 6
                      probe.instr.r_fmt.rs[2:0],          // leds 5 to 3
                      probe.instr.r_fmt.rt[2:0]};         // leds 2 to 0
        end
    end

    // ********************
    // snapshot registers
    // ********************

    always_ff @(posedge clock) begin
        if (rst) begin
            seg_frame <= '0;                              // every GPIO digit dark
            hex       <= '1;                              // active-low board digits dark
            leds      <= '0;
        end else begin
            for (int i = 0; i < `NIBBLES_PER_WORD; i++) begin
                seg_frame.data[i] <= hex_to_seg(probe.data[4*i +: 4]);
                seg_frame.addr[i] <= hex_to_seg(probe.address[4*i +: 4]);
                hex[i]            <= ~hex_to_seg(probe.pc[4*i +: 4]);  // HEX0 shows the low nibble
            end
            leds <= leds_d;
        end
    end

endmodule

`default_nettype wire

// ==== reg_scanner.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "panel_defs.svh"

module reg_scanner
    import probe_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  reg_file_t regs,
    output logic [2:0] slot,
    output logic      slot_start,
    output word_t     reg_value
);

    localparam int DIV_W = $clog2(`SCAN_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             div_wrap;
    logic [2:0]       slot_next;

    assign div_wrap  = (div_cnt == DIV_W'(`SCAN_DIV - 1));
    assign slot_next = (slot == 3'(`NUM_REGS - 1)) ? 3'd0 : slot + 3'd1;

    // ********************
    // scan divider
    // ********************

    always_ff @(posedge clock) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (div_wrap) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ********************
    // slot and register latch
    // ********************

    // the register is taken once per slot so the board never sees it change mid-slot
    always_ff @(posedge clock) begin
        if (rst) begin
            slot       <= '0;
            slot_start <= 1'b0;
            reg_value  <= '0;
        end else begin
            slot_start <= div_wrap;                  // one cycle pulse with the new slot
            if (div_wrap) begin
                slot      <= slot_next;
                reg_value <= regs[slot_next];        // register of the slot being entered
            end
        end
    end

endmodule

`default_nettype wire

// ==== panel_mux.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "panel_defs.svh"

module panel_mux
    import panel_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  seg_frame_t  seg_frame,
    input  logic [2:0]  slot,
    input  logic        slot_start,
    input  logic [15:0] reg_value,
    output gpio_word_t  gpio0
);

    seg_t [`NUM_DIGITS-1:0] digits;
    gpio_word_t             gpio_d;

    // ********************
    // digit selection
    // ********************

    // address patterns sit above the data patterns, which gives digit n at index n
    assign digits = {seg_frame.addr, seg_frame.data};

    always_comb begin
        gpio_d            = GPIO_IDLE;
        gpio_d.reg_value  = reg_value;
        gpio_d.digit_sel  = '0;
        gpio_d.digit_sel[slot] = 1'b1;               // one digit lit per slot
        gpio_d.seg_n      = ~digits[slot];           // common anode, so the pattern is inverted
        gpio_d.slot_start = slot_start;
    end

    // ********************
    // output register
    // ********************

    // the header pins come straight from flops so the ribbon cable sees clean edges
    always_ff @(posedge clock) begin
        if (rst) begin
            gpio0 <= GPIO_IDLE;
        end else begin
            gpio0 <= gpio_d;
        end
    end

endmodule

`default_nettype wire

// ==== debug_panel.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "panel_defs.svh"

module debug_panel
    import probe_pkg::*;
    import panel_pkg::*;
(
    input  logic                         clock,
    input  logic                         rst,
    input  probe_t                       probe,
    output seg_t [`NIBBLES_PER_WORD-1:0] hex,
    output logic [9:0]                   leds,
    output gpio_word_t                   gpio0
);

    seg_frame_t  seg_frame;      // decoded data and address digits
    logic [2:0]  slot;
    logic        slot_start;
    word_t       reg_value;

    // ********************
    // snapshot decode
    // ********************

    probe_decoder probe_decoder_i (
        .clock     (clock),
        .rst       (rst),
        .probe     (probe),
        .seg_frame (seg_frame),
        .hex       (hex),
        .leds      (leds)
    );

    // ********************
    // register scan
    // ********************

    reg_scanner reg_scanner_i (
        .clock      (clock),
        .rst        (rst),
        .regs       (probe.regs),
        .slot       (slot),
        .slot_start (slot_start),
        .reg_value  (reg_value)
    );

    // ********************
    // GPIO board word
    // ********************

    panel_mux panel_mux_i (
        .clock      (clock),
        .rst        (rst),
        .seg_frame  (seg_frame),
        .slot       (slot),
        .slot_start (slot_start),
        .reg_value  (reg_value),
        .gpio0      (gpio0)
    );

endmodule

`default_nettype wire

// ==== debug_panel_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "panel_defs.svh"

module debug_panel_asserts
    import probe_pkg::*;
    import panel_pkg::*;
(
    input logic                         clock,
    input logic                         rst,
    input probe_t                       probe,
    input seg_t [`NIBBLES_PER_WORD-1:0] hex,
    input logic [9:0]                   leds,
    input gpio_word_t                   gpio0
);

    // ********************
    // reference font
    // ********************

    // one mask per segment, bit n is set when hex digit n lights that segment
    localparam logic [15:0] SEG_A = 16'hd7ed;
    localparam logic [15:0] SEG_B = 16'h279f;
    localparam logic [15:0] SEG_C = 16'h2ffb;
    localparam logic [15:0] SEG_D = 16'h7b6d;
    localparam logic [15:0] SEG_E = 16'hfd45;
    localparam logic [15:0] SEG_F = 16'hdf71;
    localparam logic [15:0] SEG_G = 16'hef7c;

    // hex, leds and gpio0 as they must read while reset is held
    localparam logic [69:0] RESET_OUTPUTS = {28'hfff_ffff, 10'h000, 16'h0000, 8'h00, 7'h7f, 1'b0};

    function automatic seg_t font(input logic [3:0] n);
        return {SEG_G[n], SEG_F[n], SEG_E[n], SEG_D[n], SEG_C[n], SEG_B[n], SEG_A[n]};
    endfunction

    function automatic logic [27:0] pc_digits(input word_t pc);
        logic [27:0] d;
        for (int i = 0; i < `NIBBLES_PER_WORD; i++) begin
            d[7*i +: 7] = ~font(pc[4*i +: 4]);              // board digits are active low
        end
        return d;
    endfunction

    // opcode 31:24, rd 23:20, rs 19:16, rt 15:12, immediate 19:0
    function automatic logic [9:0] leds_rule(input logic [31:0] w);
        if (w[31]) begin
            return {1'b1, w[8:0]};
        end
        return {1'b0, w[22:20], w[18:16], w[14:12]};
    endfunction

    function automatic word_t pick_reg(input reg_file_t regs, input logic [7:0] sel);
        word_t r;
        r = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            if (sel[i]) r = regs[i];
        end
        return r;
    endfunction

    function automatic seg_t digit_seg_n(input probe_t p, input logic [7:0] sel);
        logic [31:0] nibbles;
        logic [3:0]  nib;
        nibbles = {p.address, p.data};                     // digit n shows nibble n
        nib     = '0;
        for (int i = 0; i < `NUM_DIGITS; i++) begin
            if (sel[i]) nib = nibbles[4*i +: 4];
        end
        return ~font(nib);
    endfunction

    // ********************
    // history and expected values
    // ********************

    logic        rst_q = 1'b0;
    logic        rst_qq = 1'b0;
    probe_t      probe_q;
    probe_t      probe_qq;
    gpio_word_t  gpio_q;
    int          gap;                                      // cycles since the last gpio0 pulse
    logic        seen_pulse;
    int          gap_limit;
    logic [27:0] exp_hex;
    logic [9:0]  exp_leds;
    logic [7:0]  exp_sel;
    word_t       exp_reg;
    seg_t        exp_seg_n;
    logic        bad_reset = 1'b0;
    logic        bad_hex = 1'b0;
    logic        bad_leds = 1'b0;
    logic        bad_pulse = 1'b0;
    logic        bad_onehot = 1'b0;
    logic        bad_sel = 1'b0;
    logic        bad_reg = 1'b0;
    logic        bad_seg = 1'b0;
    logic        failed;

    always @(posedge clock) begin
        rst_q    <= rst;
        rst_qq   <= rst_q;
        probe_q  <= probe;
        probe_qq <= probe_q;
        gpio_q   <= gpio0;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            gap        <= 0;
            seen_pulse <= 1'b0;
        end else if (gpio0.slot_start) begin
            gap        <= 1;
            seen_pulse <= 1'b1;
        end else begin
            gap <= gap + 1;
        end
    end

    // the first pulse also carries the cycle of reset release
    assign gap_limit = seen_pulse ? `SCAN_DIV : `SCAN_DIV + 1;
    assign exp_hex   = pc_digits(probe_q.pc);
    assign exp_leds  = leds_rule(probe_q.instr);
    assign exp_sel   = rst_qq ? 8'h01                               // slot 0 after reset
                     : gpio0.slot_start ? {gpio_q.digit_sel[`NUM_DIGITS-2:0],
                                           gpio_q.digit_sel[`NUM_DIGITS-1]}
                     : gpio_q.digit_sel;
    assign exp_reg   = gpio0.slot_start ? pick_reg(probe_qq.regs, gpio0.digit_sel)
                                        : gpio_q.reg_value;
    assign exp_seg_n = digit_seg_n(probe_qq, gpio0.digit_sel);
    assign failed    = bad_reset | bad_hex | bad_leds | bad_pulse
                     | bad_onehot | bad_sel | bad_reg | bad_seg;

    // ********************
    // output rules
    // ********************

    reset_outputs: assert property (@(posedge clock) rst_q |-> {hex, leds, gpio0} == RESET_OUTPUTS)
    else begin
        bad_reset = 1'b1;
        $error("mismatch at %0t: {hex, leds, gpio0} is %h, expected %h", $time,
               $sampled({hex, leds, gpio0}), RESET_OUTPUTS);
    end

    hex_follows_pc: assert property (@(posedge clock) disable iff (rst) !rst_q |-> hex == exp_hex)
    else begin
        bad_hex = 1'b1;
        $error("mismatch at %0t: hex is %h, expected %h", $time, $sampled(hex), $sampled(exp_hex));
    end

    leds_follow_instr: assert property (@(posedge clock) disable iff (rst)
        !rst_q |-> leds == exp_leds)
    else begin
        bad_leds = 1'b1;
        $error("mismatch at %0t: leds is %b, expected %b", $time,
               $sampled(leds), $sampled(exp_leds));
    end

    pulse_period: assert property (@(posedge clock) disable iff (rst)
        gpio0.slot_start == (gap == gap_limit))
    else begin
        bad_pulse = 1'b1;
        $error(
            "mismatch at %0t: gpio0.slot_start is %b after %0d cycles, expected a pulse after %0d",
            $time, $sampled(gpio0.slot_start), $sampled(gap), $sampled(gap_limit));
    end

    select_onehot: assert property (@(posedge clock) disable iff (rst)
        !rst_q |-> $onehot(gpio0.digit_sel))
    else begin
        bad_onehot = 1'b1;
        $error("gpio0.digit_sel is %b at %0t, which is not one-hot",
               $sampled(gpio0.digit_sel), $time);
    end

    select_rotates: assert property (@(posedge clock) disable iff (rst)
        !rst_q |-> gpio0.digit_sel == exp_sel)
    else begin
        bad_sel = 1'b1;
        $error("mismatch at %0t: gpio0.digit_sel is %b, expected %b", $time,
               $sampled(gpio0.digit_sel), $sampled(exp_sel));
    end

    reg_value_held: assert property (@(posedge clock) disable iff (rst)
        !rst_q && !rst_qq |-> gpio0.reg_value == exp_reg)
    else begin
        bad_reg = 1'b1;
        $error("mismatch at %0t: gpio0.reg_value is %h, expected %h", $time,
               $sampled(gpio0.reg_value), $sampled(exp_reg));
    end

    seg_matches_digit: assert property (@(posedge clock) disable iff (rst)
        !rst_q && !rst_qq |-> gpio0.seg_n == exp_seg_n)
    else begin
        bad_seg = 1'b1;
        $error("mismatch at %0t: gpio0.seg_n is %h, expected %h", $time,
               $sampled(gpio0.seg_n), $sampled(exp_seg_n));
    end

endmodule

`default_nettype wire

// ==== debug_panel_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "panel_defs.svh"

module debug_panel_tb
    import probe_pkg::*;
    import panel_pkg::*;
();

    localparam int HALF_PERIOD     = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int ROUND_CYCLES    = `NUM_REGS * `SCAN_DIV;    // one pass over all slots
    localparam int BURST_CYCLES    = 2 * `SCAN_DIV;            // probe changes every cycle
    localparam int HOLD_CYCLES     = 2 * ROUND_CYCLES;         // probe held still
    localparam int PHASES          = 14;
    localparam int WATCHDOG_CYCLES = 40 * ROUND_CYCLES + 200;

    logic                         clock = 1'b0;
    logic                         rst;
    probe_t                       probe;
    seg_t [`NIBBLES_PER_WORD-1:0] hex;
    logic [9:0]                   leds;
    gpio_word_t                   gpio0;
    logic [31:0]                  lfsr_state;

    debug_panel debug_panel_i (
        .clock (clock),
        .rst   (rst),
        .probe (probe),
        .hex   (hex),
        .leds  (leds),
        .gpio0 (gpio0)
    );

    bind debug_panel debug_panel_asserts debug_panel_asserts_i (
        .clock (clock),
        .rst   (rst),
        .probe (probe),
        .hex   (hex),
        .leds  (leds),
        .gpio0 (gpio0)
    );

    always #HALF_PERIOD clock = ~clock;

    // ********************
    // stimulus helpers
    // ********************

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_probe(output probe_t p);
        logic [$bits(probe_t)-1:0] bits;
        for (int i = 0; i < $bits(probe_t); i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i]    = lfsr_state[0];                 // one step per bit taken
        end
        p = bits;
    endtask

    // phases start on a slot boundary so every hold covers whole scan rounds
    task automatic wait_slot_pulse();
        do begin
            @(negedge clock);
        end while (!gpio0.slot_start);
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin
        probe_t next_probe;
        rst        = 1'b1;
        probe      = '0;
        lfsr_state = 32'h77d0cbe0;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        for (int phase = 0; phase < PHASES; phase++) begin
            wait_slot_pulse();
            repeat (BURST_CYCLES) begin
                random_probe(next_probe);
                probe = next_probe;
                @(negedge clock);
            end
            random_probe(next_probe);
            probe = next_probe;
            repeat (HOLD_CYCLES) @(negedge clock);
        end
        repeat (4) @(negedge clock);                   // drain the two-stage GPIO path
        if (debug_panel_i.debug_panel_asserts_i.failed) begin
            $display("Simulation failed");
            $fatal(1, "an output check failed before the end of the run");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // an assertion failure raises the checker flag, seen on the next falling edge
    always @(negedge clock) begin
        if (debug_panel_i.debug_panel_asserts_i.failed) begin
            $display("Simulation failed");
            $fatal(1, "an output check failed, the assertion error above has the details");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Simulation failed");
        $fatal(1, "watchdog expired, the stimulus did not finish within %0d cycles",
               WATCHDOG_CYCLES);
    end

endmodule

`default_nettype wire

// ==== debug_panel.f ====
+incdir+.
probe_pkg.sv
panel_pkg.sv
probe_decoder.sv
reg_scanner.sv
panel_mux.sv
debug_panel.sv
debug_panel_asserts.sv
debug_panel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, the exit status is the verdict
# the error limit lets the testbench print its own verdict after an assertion error
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module debug_panel_tb -f debug_panel.f \
    -o debug_panel_sim &&
./obj_dir/debug_panel_sim +verilator+error+limit+1000 ||
{ echo "debug_panel simulation did not pass"; exit 1; }
